/* rtl/ising_pkg.sv */
// Ising solver shared types
package ising_pkg;

    // Width of a node index
    localparam int IDX_W = 2;

    // Largest array that a node index can address
    localparam int MAX_NODES = 1 << IDX_W;

    // Coupling strength codes, ordered from strong negative to strong positive
    // Codes 101 to 111 are not valid and get clamped to zero on write
    typedef enum logic [2:0] {
        CPL_NEG2 = 3'b000,
        CPL_NEG1 = 3'b001,
        CPL_ZERO = 3'b010,
        CPL_POS1 = 3'b011,
        CPL_POS2 = 3'b100
    } coupling_code_t;

    // Selects how the payload is decoded
    typedef enum logic {
        OP_WEIGHT  = 1'b0,
        OP_CONTROL = 1'b1
    } cfg_op_t;

    // Weight write fields
    typedef struct packed {
        logic [IDX_W-1:0] row;
        logic [IDX_W-1:0] col;
        coupling_code_t   code;
        logic [8:0]       pad;
    } weight_fields_t;

    // Control write fields
    typedef struct packed {
        logic        run;
        logic        start;
        logic [13:0] pad;
    } control_fields_t;

    // One 16-bit payload, read as weight or control fields by opcode
    typedef union packed {
        weight_fields_t  weight;
        control_fields_t control;
    } cfg_payload_u;

    // Full configuration word, 17 bits
    typedef struct packed {
        cfg_op_t      op;
        cfg_payload_u payload;
    } cfg_word_t;

    // Per-node outcome of one sampling window
    // Sized for the largest array, bits at or above NODES stay 0
    typedef struct packed {
        logic [MAX_NODES-1:0] alive;
        logic [MAX_NODES-1:0] spin;
    } node_result_t;

endpackage

/* rtl/oscillator.sv */
// Coupled ring oscillator
`timescale 1ns/1ps

// Ring layout, wave[0] is the inverter output
//
//     PORTS  wave     0
//  |---<---<---<---<---|
//  |                   |-- out
//  |-->o-->->->->------|
//          padding

module oscillator import ising_pkg::*; #(
    parameter int PORTS = 4
) (
    input  logic [3*PORTS-1:0] coupling_weights,
    input  logic [PORTS-1:0]   coupling_inputs,
    input  logic               run,
    output logic               out
);

    wire [PORTS:0]   wave;
    wire [PORTS:0]   pad;
    wire [PORTS-1:0] couple;

    // Inverter closes the ring through the padding chain
    assign wave[0] = run ? ~pad[PORTS] : 1'b0;
    assign out     = wave[0];
    assign pad[0]  = wave[PORTS];

    // Padding stages, five unit delays each
    // They lengthen the loop so the coupled taps do not cause ringing
    for (genvar i = 1; i <= PORTS; i++) begin : g_pad
        wire [4:0] dly;

        assign #1 dly[0] = pad[i-1];
        for (genvar k = 1; k < 5; k++) begin : g_dly
            assign #1 dly[k] = dly[k-1];
        end
        assign pad[i] = run ? dly[4] : 1'b0;
    end

    // Coupling only acts while we are low and the neighbour is high
    // Positive codes pull us up early, negative codes hold us back
    // With the roles swapped, the neighbour's own ring does the adjusting
    assign couple = run ? (coupling_inputs & {PORTS{~out}}) : '0;

    // Coupled stages, five unit delays with a selectable tap
    for (genvar i = 1; i <= PORTS; i++) begin : g_couple
        coupling_code_t weight;
        wire [4:0]      tap;
        logic           stage;

        assign weight = coupling_code_t'(coupling_weights[(i-1)*3 +: 3]);

        // tap[0] is one delay, tap[4] is five
        assign #1 tap[0] = wave[i-1];
        for (genvar k = 1; k < 5; k++) begin : g_tap
            assign #1 tap[k] = tap[k-1];
        end

        // Middle tap is the nominal path when coupling is idle
        always_comb begin
            stage = tap[2];
            if (couple[i-1]) begin
                case (weight)
                    CPL_POS2: stage = tap[0];
                    CPL_POS1: stage = tap[1];
                    CPL_NEG1: stage = tap[3];
                    CPL_NEG2: stage = tap[4];
                    default:  stage = tap[2];
                endcase
            end
        end

        assign wave[i] = run ? stage : 1'b0;
    end

endmodule

/* rtl/coupling_matrix.sv */
// Coupling matrix and run control
`timescale 1ns/1ps

module coupling_matrix import ising_pkg::*; #(
    parameter int NODES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_valid,
    input  cfg_word_t                cfg,
    input  logic [IDX_W-1:0]         rd_row,
    input  logic [IDX_W-1:0]         rd_col,
    output coupling_code_t           rd_code,
    output logic [NODES*NODES*3-1:0] weights,
    output logic                     run,
    output logic                     start
);

    coupling_code_t  codes [NODES][NODES];
    weight_fields_t  wf;
    control_fields_t cf;
    coupling_code_t  wr_code;
    logic            wr_en;
    logic            ctl_en;

    // Same payload bits, two views
    assign wf = cfg.payload.weight;
    assign cf = cfg.payload.control;

    // Out-of-range codes land on zero coupling
    assign wr_code = (wf.code > CPL_POS2) ? CPL_ZERO : wf.code;

    // Self coupling stays at zero, diagonal writes are dropped
    assign wr_en = cfg_valid && (cfg.op == OP_WEIGHT) && (wf.row != wf.col) &&
                   (int'(wf.row) < NODES) && (int'(wf.col) < NODES);

    assign ctl_en = cfg_valid && (cfg.op == OP_CONTROL);

    // Code registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NODES; r++) begin
                for (int c = 0; c < NODES; c++) begin
                    codes[r][c] <= CPL_ZERO;
                end
            end
        end else if (wr_en) begin
            codes[wf.row][wf.col] <= wr_code;
        end
    end

    // Run level and one-cycle start strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run   <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= ctl_en && cf.start;
            if (ctl_en) begin
                run <= cf.run;
            end
        end
    end

    // Registered readback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_code <= CPL_ZERO;
        end else if ((int'(rd_row) < NODES) && (int'(rd_col) < NODES)) begin
            rd_code <= codes[rd_row][rd_col];
        end else begin
            rd_code <= CPL_ZERO;
        end
    end

    // Flatten row by row, row r feeds oscillator r
    always_comb begin
        for (int r = 0; r < NODES; r++) begin
            for (int c = 0; c < NODES; c++) begin
                weights[(r*NODES + c)*3 +: 3] = codes[r][c];
            end
        end
    end

endmodule

/* rtl/phase_sampler.sv */
// Oscillator phase sampler
`timescale 1ns/1ps

module phase_sampler import ising_pkg::*; #(
    parameter int NODES  = 4,
    parameter int WINDOW = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [NODES-1:0] osc_out,
    output logic             done,
    output node_result_t     result
);

    localparam int CNT_W = $clog2(WINDOW + 1);

    logic [NODES-1:0] sync1;
    logic [NODES-1:0] sync2;
    logic [NODES-1:0] prev;
    logic             active;
    logic             finish;
    logic [CNT_W-1:0] cycle_cnt;
    logic [1:0]       edge_cnt  [NODES];
    logic [CNT_W-1:0] agree_cnt [NODES];
    node_result_t     next_result;

    // Two-flop synchronizer for the free-running rings
    // prev holds the last synchronized sample for edge detection
    always_ff @(posedge clk) begin
        sync1 <= osc_out;
        sync2 <= sync1;
        prev  <= sync2;
    end

    // Window control
    // start is the setup cycle, then WINDOW sampling cycles follow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            finish    <= 1'b0;
            cycle_cnt <= '0;
        end else if (start) begin
            active    <= 1'b1;
            finish    <= 1'b0;
            cycle_cnt <= '0;
        end else begin
            finish <= active && (cycle_cnt == CNT_W'(WINDOW - 1));
            if (active) begin
                cycle_cnt <= cycle_cnt + 1'b1;
                if (cycle_cnt == CNT_W'(WINDOW - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Per-node counters
    // Edge count saturates at two, that is all liveness needs
    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            for (int n = 0; n < NODES; n++) begin
                edge_cnt[n]  <= '0;
                agree_cnt[n] <= '0;
            end
        end else if (active) begin
            for (int n = 0; n < NODES; n++) begin
                if ((sync2[n] != prev[n]) && (edge_cnt[n] != 2'd2)) begin
                    edge_cnt[n] <= edge_cnt[n] + 2'd1;
                end
                // Agreement is measured against node 0
                if (sync2[n] == sync2[0]) begin
                    agree_cnt[n] <= agree_cnt[n] + 1'b1;
                end
            end
        end
    end

    // Decide alive and spin from the final counts
    always_comb begin
        next_result = '0;
        for (int n = 0; n < NODES; n++) begin
            next_result.alive[n] = (edge_cnt[n] == 2'd2);
            next_result.spin[n]  = (agree_cnt[n] > CNT_W'(WINDOW / 2));
        end
    end

    // Result register and done pulse
    // A new start wins over a window that is just closing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= finish && !start;
            if (start) begin
                result <= '0;
            end else if (finish) begin
                result <= next_result;
            end
        end
    end

endmodule

/* rtl/ising_top.sv */
// Oscillator Ising solver top
`timescale 1ns/1ps

module ising_top import ising_pkg::*; #(
    // NODES must fit the IDX_W index range
    parameter int NODES  = 4,
    parameter int WINDOW = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_valid,
    input  cfg_word_t        cfg,
    input  logic [IDX_W-1:0] rd_row,
    input  logic [IDX_W-1:0] rd_col,
    output coupling_code_t   rd_code,
    output logic             done,
    output node_result_t     result
);

    logic [NODES*NODES*3-1:0] weights;
    logic                     run;
    logic                     start;
    logic [NODES-1:0]         osc_out;

    // Configuration, readback and run control
    coupling_matrix #(
        .NODES(NODES)
    ) i_coupling_matrix (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_valid(cfg_valid),
        .cfg      (cfg),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_code  (rd_code),
        .weights  (weights),
        .run      (run),
        .start    (start)
    );

    // One ring per node
    // Every ring hears every output, its own port sits at zero coupling
    for (genvar r = 0; r < NODES; r++) begin : g_osc
        oscillator #(
            .PORTS(NODES)
        ) i_oscillator (
            .coupling_weights(weights[r*NODES*3 +: NODES*3]),
            .coupling_inputs (osc_out),
            .run             (run),
            .out             (osc_out[r])
        );
    end

    // Liveness and spin measurement
    phase_sampler #(
        .NODES (NODES),
        .WINDOW(WINDOW)
    ) i_phase_sampler (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .osc_out(osc_out),
        .done   (done),
        .result (result)
    );

endmodule

/* test/tb_ising.sv */
// Ising solver testbench
`timescale 1ns/1ps

module tb_ising import ising_pkg::*;;

    localparam int    NODES        = 4;
    localparam int    WINDOW       = 64;
    localparam int    RESET_CYCLES = 8;
    localparam int    RAND_PAIRS   = 8;
    localparam string INPUT_FILE   = "test/tb_ising_input.txt";

    logic             clk;
    logic             rst_n;
    logic             cfg_valid;
    cfg_word_t        cfg;
    logic [IDX_W-1:0] rd_row;
    logic [IDX_W-1:0] rd_col;
    coupling_code_t   rd_code;
    logic             done;
    node_result_t     result;

    // Test table with one entry per stimulus line
    string       name_q [$];
    string       kind_q [$];
    int          a_q    [$];
    int          b_q    [$];
    int          c_q    [$];
    logic [31:0] exp_q  [$];
    logic [31:0] mask_q [$];

    int   n_checks;
    int   n_errors;
    int   cycle_limit;
    int   cycles;
    logic limit_ready;

    ising_top #(
        .NODES (NODES),
        .WINDOW(WINDOW)
    ) i_ising_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_valid(cfg_valid),
        .cfg      (cfg),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_code  (rd_code),
        .done     (done),
        .result   (result)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog armed once the test table is known
    initial begin
        cycles = 0;
        wait (limit_ready);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    // Numerical Recipes LCG step
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_code(input string name, input coupling_code_t expected,
                              input coupling_code_t actual);
        n_checks++;
        if (actual === expected) begin
            $display("ok      %s  code %0d", name, actual);
        end else begin
            n_errors++;
            $display("** Error %s: expected code %0d, actual code %0d", name, expected, actual);
        end
    endtask

    // Only bits set in mask take part in the compare
    task automatic check_result(input string name, input node_result_t expected,
                                input node_result_t actual, input node_result_t mask);
        node_result_t got;
        node_result_t want;
        got  = actual & mask;
        want = expected & mask;
        n_checks++;
        if (got === want) begin
            $display("ok      %s  result %h", name, actual);
        end else begin
            n_errors++;
            $display("** Error %s: expected result %h, actual result %h (mask %h)",
                     name, expected, actual, mask);
        end
    endtask

    // Reads the stimulus table
    // Lines starting with # are skipped
    task automatic load_tests(output logic ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        string       kind;
        int          a;
        int          b;
        int          c;
        logic [31:0] expected;
        logic [31:0] mask;
        ok = 1'b0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %d %d %d %h %h",
                                name, kind, a, b, c, expected, mask);
                    if (n == 7) begin
                        name_q.push_back(name);
                        kind_q.push_back(kind);
                        a_q.push_back(a);
                        b_q.push_back(b);
                        c_q.push_back(c);
                        exp_q.push_back(expected);
                        mask_q.push_back(mask);
                    end else begin
                        $display("Malformed stimulus line: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds a config word for one clock and returns on the next falling edge
    task automatic drive_cfg(input cfg_word_t w);
        cfg_valid = 1'b1;
        cfg       = w;
        @(negedge clk);
        cfg_valid = 1'b0;
        cfg       = '0;
    endtask

    task automatic write_code(input int row, input int col, input int code);
        cfg_word_t w;
        w = '0;
        w.op                  = OP_WEIGHT;
        w.payload.weight.row  = IDX_W'(row);
        w.payload.weight.col  = IDX_W'(col);
        w.payload.weight.code = coupling_code_t'(code[2:0]);
        drive_cfg(w);
    endtask

    // Readback is registered, so the code is checked one edge later
    task automatic read_code(input string name, input int row, input int col,
                             input coupling_code_t expected);
        rd_row = IDX_W'(row);
        rd_col = IDX_W'(col);
        @(negedge clk);
        if (done !== 1'b0) begin
            n_errors++;
            $display("%s: done is high while no window is running", name);
        end
        check_code(name, expected, rd_code);
    endtask

    // gap above zero sends a first start and restarts after gap cycles
    task automatic run_window(input string name, input logic run_lvl, input int gap,
                              input node_result_t expected, input node_result_t mask);
        cfg_word_t w;
        int        waited;
        w = '0;
        w.op                    = OP_CONTROL;
        w.payload.control.run   = run_lvl;
        w.payload.control.start = 1'b1;
        if (gap > 0) begin
            drive_cfg(w);
            repeat (gap) begin
                if (done !== 1'b0) begin
                    n_errors++;
                    $display("%s: done pulsed before the restart strobe", name);
                end
                @(negedge clk);
            end
        end
        drive_cfg(w);
        // Rising edges seen since the strobe was driven
        waited = 1;
        while (done !== 1'b1 && waited <= WINDOW + 6) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            n_errors++;
            $display("%s: done never came after the start strobe", name);
        end else begin
            if (waited != WINDOW + 3) begin
                n_errors++;
                $display("** Error %s: expected done after %0d cycles, actual %0d cycles",
                         name, WINDOW + 3, waited);
            end
            check_result(name, expected, result, mask);
            @(negedge clk);
            if (done !== 1'b0) begin
                n_errors++;
                $display("%s: done stayed high for more than one cycle", name);
            end
        end
    endtask

    task automatic run_test(input int i);
        logic [31:0] e;
        logic [31:0] m;
        e = exp_q[i];
        m = mask_q[i];
        if (kind_q[i] == "write") begin
            write_code(a_q[i], b_q[i], c_q[i]);
            $display("wrote   %s", name_q[i]);
        end else if (kind_q[i] == "read") begin
            read_code(name_q[i], a_q[i], b_q[i], coupling_code_t'(e[2:0]));
        end else if (kind_q[i] == "run") begin
            run_window(name_q[i], a_q[i] != 0, b_q[i],
                       node_result_t'(e[$bits(node_result_t)-1:0]),
                       node_result_t'(m[$bits(node_result_t)-1:0]));
        end else begin
            n_errors++;
            $display("%s: unknown test kind %s", name_q[i], kind_q[i]);
        end
    endtask

    // Off-diagonal write and readback of random valid codes
    task automatic random_pairs();
        logic [31:0] state;
        int          row;
        int          col;
        int          v;
        state = 32'h80e9;
        for (int p = 0; p < RAND_PAIRS; p++) begin
            state = lcg_next(state);
            row   = int'(state[17:16]);
            // Step one to three places away from the diagonal
            col   = (row + 1 + int'(state[23:20]) % 3) % NODES;
            v     = int'(state[31:24]) % 5;
            write_code(row, col, v);
            read_code($sformatf("lcg_pair_%0d", p), row, col, coupling_code_t'(v[2:0]));
        end
    endtask

    initial begin
        logic ok;
        cfg_valid   = 1'b0;
        cfg         = '0;
        rd_row      = '0;
        rd_col      = '0;
        rst_n       = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        limit_ready = 1'b0;
        load_tests(ok);
        // 8 cycles per test plus a full window and any restart gap per run
        cycle_limit = RESET_CYCLES + 8 * (name_q.size() + 2 * RAND_PAIRS);
        foreach (kind_q[i]) begin
            if (kind_q[i] == "run") begin
                cycle_limit += WINDOW + 10 + b_q[i];
            end
        end
        limit_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (!ok) begin
            n_errors++;
            $display("Could not read a valid test table from %s", INPUT_FILE);
        end else begin
            foreach (name_q[i]) begin
                run_test(i);
            end
            random_pairs();
        end
        $display("Finished: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
rtl/ising_pkg.sv
rtl/oscillator.sv
rtl/coupling_matrix.sv
rtl/phase_sampler.sv
rtl/ising_top.sv
test/tb_ising.sv

/* build.sh */
#!/bin/sh
# Compile and run the Ising solver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb_ising

# Build the simulation executable
verilator --binary --timing -Wno-fatal --top-module tb_ising -f build.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Run the simulation from the project root so the stimulus path resolves
./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the verdict
if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

/* test/tb_ising_input.txt */
# name kind a b c expect mask, with a b c decimal and expect mask hex
# write a=row b=col c=code, read a=row b=col expect=code, run a=run b=restart gap expect=result
rst_rd_00 read 0 0 0 2 0
rst_rd_01 read 0 1 0 2 0
rst_rd_02 read 0 2 0 2 0
rst_rd_03 read 0 3 0 2 0
rst_rd_10 read 1 0 0 2 0
rst_rd_11 read 1 1 0 2 0
rst_rd_12 read 1 2 0 2 0
rst_rd_13 read 1 3 0 2 0
rst_rd_20 read 2 0 0 2 0
rst_rd_21 read 2 1 0 2 0
rst_rd_22 read 2 2 0 2 0
rst_rd_23 read 2 3 0 2 0
rst_rd_30 read 3 0 0 2 0
rst_rd_31 read 3 1 0 2 0
rst_rd_32 read 3 2 0 2 0
rst_rd_33 read 3 3 0 2 0
run_low run 0 0 0 0f ff
run_high_zero run 1 0 0 f1 f1
restart_low run 0 20 0 0f ff
wr_01 write 0 1 4 0 0
rd_01 read 0 1 0 4 0
wr_10 write 1 0 0 0 0
rd_10 read 1 0 0 0 0
wr_23 write 2 3 1 0 0
rd_23 read 2 3 0 1 0
wr_32 write 3 2 3 0 0
rd_32 read 3 2 0 3 0
wr_diag_11 write 1 1 4 0 0
rd_diag_11 read 1 1 0 2 0
wr_02_valid write 0 2 3 0 0
wr_02_bad write 0 2 7 0 0
rd_02_clamp read 0 2 0 2 0
wr_21_zero write 2 1 2 0 0
wr_21_pos2 write 2 1 4 0 0
rd_21 read 2 1 0 4 0
wr_30_bad write 3 0 5 0 0
rd_30_clamp read 3 0 0 2 0
rd_01_again read 0 1 0 4 0
